//--- common/core_pkg.sv
/*
 * Shared definitions for the integer execute stage.
 * Widths, opcode and funct3 codes, the instruction word views
 * and the items passed between the stage registers.
 */
`default_nettype none

package core_pkg;

    // ----------------------------------------------------------
    // Widths
    // ----------------------------------------------------------
    localparam int XLEN = 64;         // Register width
    localparam int XL   = XLEN - 1;   // Top bit index

    // ----------------------------------------------------------
    // Major opcodes
    // ----------------------------------------------------------
    localparam logic [6:0] OPC_OP        = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM    = 7'b0010011;
    localparam logic [6:0] OPC_OP_32     = 7'b0111011;
    localparam logic [6:0] OPC_OP_IMM_32 = 7'b0011011;
    localparam logic [6:0] OPC_BRANCH    = 7'b1100011;

    // ALU funct3
    localparam logic [2:0] F3_ADD  = 3'b000;   // Also SUB
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101;   // SRL or SRA
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    // Branch funct3
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    // ----------------------------------------------------------
    // Instruction word, R-type and I-type views
    // ----------------------------------------------------------
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } instr_r_t;

    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } instr_i_t;

    typedef union packed {
        instr_r_t r;
        instr_i_t i;
    } instr_u;

    // Input item, 160 bits
    typedef struct packed {
        instr_u      instr;
        logic [XL:0] rs1_val;
        logic [XL:0] rs2_val;
    } exec_in_t;

    // One-hot style ALU selects plus word mode
    typedef struct packed {
        logic op_add;
        logic op_sub;
        logic op_xor;
        logic op_or;
        logic op_and;
        logic op_slt;
        logic op_sltu;
        logic op_srl;
        logic op_sll;
        logic op_sra;
        logic word;
    } alu_ctl_t;

    // Decode register contents
    typedef struct packed {
        alu_ctl_t    ctl;
        logic [XL:0] opr_a;
        logic [XL:0] opr_b;
        logic [2:0]  funct3;
        logic        is_branch;
        logic        illegal;
    } dec_t;

    // Output item, 67 bits
    typedef struct packed {
        logic [XL:0] result;
        logic        taken;
        logic        is_branch;
        logic        illegal;
    } exec_res_t;

endpackage

`default_nettype wire

//--- core_pipe_exec/core_pipe_exec_alu.sv
/*
 * Integer ALU for RV64.
 * Add/sub, signed and unsigned compare, bitwise ops and shifts,
 * with 32-bit word variants sign extended to the full width.
 */
`timescale 1ns/1ns
`default_nettype none

module core_pipe_exec_alu (
    input  wire [core_pkg::XL:0] opr_a,     // Operand A
    input  wire [core_pkg::XL:0] opr_b,     // Operand B
    input  wire                  word,      // Low 32-bit operation
    input  wire                  op_add,
    input  wire                  op_sub,    // A - B
    input  wire                  op_xor,
    input  wire                  op_or,
    input  wire                  op_and,
    input  wire                  op_slt,    // Signed set less than
    input  wire                  op_sltu,   // Unsigned set less than
    input  wire                  op_srl,
    input  wire                  op_sll,
    input  wire                  op_sra,
    output wire [core_pkg::XL:0] add_out,   // Raw adder output
    output wire                  cmp_eq,    // A == B
    output wire                  cmp_lt,    // A < B signed
    output wire                  cmp_ltu,   // A < B unsigned
    output wire [core_pkg::XL:0] result
);

    assign cmp_eq = (opr_a == opr_b);

    // ----------------------------------------------------------
    // Adder
    // ----------------------------------------------------------
    // Subtract as A + ~B + 1
    wire [core_pkg::XL:0] add_rhs = op_sub ? ~opr_b : opr_b;
    wire [core_pkg::XL:0] add_sum = opr_a + add_rhs + {{core_pkg::XL{1'b0}}, op_sub};

    assign add_out = add_sum;

    wire [31:0]           add_hi  = word ? {32{add_sum[31]}} : add_sum[core_pkg::XL:32];
    wire [core_pkg::XL:0] add_res = {add_hi, add_sum[31:0]};

    // ----------------------------------------------------------
    // Compares
    // ----------------------------------------------------------
    wire lt_s    = $signed(opr_a) < $signed(opr_b);
    wire lt_s_w  = $signed(opr_a[31:0]) < $signed(opr_b[31:0]);
    wire lt_u    = opr_a < opr_b;
    wire lt_u_w  = opr_a[31:0] < opr_b[31:0];

    assign cmp_lt  = word ? lt_s_w : lt_s;
    assign cmp_ltu = word ? lt_u_w : lt_u;

    wire [core_pkg::XL:0] slt_res = {{core_pkg::XL{1'b0}}, op_slt ? cmp_lt : cmp_ltu};

    // ----------------------------------------------------------
    // Bitwise
    // ----------------------------------------------------------
    wire [core_pkg::XL:0] bit_res =
        ({core_pkg::XLEN{op_xor}} & (opr_a ^ opr_b)) |
        ({core_pkg::XLEN{op_or }} & (opr_a | opr_b)) |
        ({core_pkg::XLEN{op_and}} & (opr_a & opr_b));

    // ----------------------------------------------------------
    // Shifts
    // ----------------------------------------------------------
    // One right shifter; left shift by reversing bits in and out
    wire [core_pkg::XL:0] shl_in;
    wire [core_pkg::XL:0] shl_out;

    wire [core_pkg::XL:0] shr_in  = {word ? 32'b0 : opr_a[core_pkg::XL:32], opr_a[31:0]};
    wire [core_pkg::XL:0] sh_in   = op_sll ? shl_in : shr_in;
    wire [5:0]            sh_amt  = {!word && opr_b[5], opr_b[4:0]};   // 5 bits in word mode
    wire [core_pkg::XL:0] shr_out = sh_in >> sh_amt;

    for (genvar i = 0; i < core_pkg::XLEN; i = i + 1) begin : g_rev
        assign shl_in[i]  = shr_in[core_pkg::XL-i];
        assign shl_out[i] = shr_out[core_pkg::XL-i];
    end

    // Sign fill mask for arithmetic shifts, top sh_amt bits
    wire                  sh_sign = word ? opr_a[31] : opr_a[core_pkg::XL];
    wire [core_pkg::XL:0] sh_mask = sh_sign ? ~({core_pkg::XLEN{1'b1}} >> sh_amt) : '0;

    // Word SRA uses the upper mask half on the low word
    wire [core_pkg::XL:0] sraw_res = {
        {32{shr_in[31] || sh_mask[core_pkg::XL]}},
        shr_out[31:0] | sh_mask[core_pkg::XL:32]
    };
    wire [core_pkg::XL:0] sra_res  = shr_out | sh_mask;

    wire [core_pkg::XL:0] sh_res =
        ({core_pkg::XLEN{op_sll &&  word}} & {{32{shl_out[31]}}, shl_out[31:0]}) |
        ({core_pkg::XLEN{op_srl &&  word}} & {{32{shr_out[31]}}, shr_out[31:0]}) |
        ({core_pkg::XLEN{op_sra &&  word}} & sraw_res)                           |
        ({core_pkg::XLEN{op_sll && !word}} & shl_out)                            |
        ({core_pkg::XLEN{op_srl && !word}} & shr_out)                            |
        ({core_pkg::XLEN{op_sra && !word}} & sra_res);

    // ----------------------------------------------------------
    // Result OR-mux
    // ----------------------------------------------------------
    wire sel_add = op_add || op_sub;
    wire sel_slt = op_slt || op_sltu;
    wire sel_sh  = op_sll || op_srl || op_sra;

    assign result = bit_res                                |
                    ({core_pkg::XLEN{sel_add}} & add_res)  |
                    ({core_pkg::XLEN{sel_slt}} & slt_res)  |
                    ({core_pkg::XLEN{sel_sh }} & sh_res);

endmodule

`default_nettype wire

//--- core_pipe_exec/core_pipe_exec_branch.sv
/*
 * Branch condition evaluation.
 * Picks one ALU compare flag by branch funct3.
 */
`timescale 1ns/1ns
`default_nettype none

module core_pipe_exec_branch (
    input  wire       is_branch,
    input  wire [2:0] funct3,
    input  wire       cmp_eq,
    input  wire       cmp_lt,     // Signed
    input  wire       cmp_ltu,    // Unsigned
    output logic      taken
);

    logic cond;

    always_comb begin
        case (funct3)
            core_pkg::F3_BEQ:  cond = cmp_eq;
            core_pkg::F3_BNE:  cond = !cmp_eq;
            core_pkg::F3_BLT:  cond = cmp_lt;
            core_pkg::F3_BGE:  cond = !cmp_lt;
            core_pkg::F3_BLTU: cond = cmp_ltu;
            core_pkg::F3_BGEU: cond = !cmp_ltu;
            default:           cond = 1'b0;   // 010 and 011 unused
        endcase
    end

    // Non-branch items never report taken
    assign taken = is_branch && cond;

endmodule

`default_nettype wire

//--- core_pipe_exec/core_pipe_exec_decode.sv
/*
 * Execute stage decode register.
 * Turns the instruction word into ALU selects, picks operand B
 * and holds the result for one cycle under valid/ready control.
 */
`timescale 1ns/1ns
`default_nettype none

module core_pipe_exec_decode (
    input  wire                 g_clk,
    input  wire                 rst_n,
    input  wire                 in_valid,
    output wire                 in_ready,
    input  core_pkg::exec_in_t  in_item,
    input  wire                 advance,    // Downstream takes dec this cycle
    output logic                dec_valid,
    output core_pkg::dec_t      dec
);

    logic [6:0]          opcode;
    logic [2:0]          funct3;
    logic                alt;          // funct7 bit 5
    logic                imm_form;
    logic                word_form;
    logic [core_pkg::XL:0] imm_sext;
    core_pkg::dec_t      dec_nxt;

    assign opcode    = in_item.instr.r.opcode;
    assign funct3    = in_item.instr.r.funct3;
    assign alt       = in_item.instr.r.funct7[5];
    assign imm_form  = (opcode == core_pkg::OPC_OP_IMM) ||
                       (opcode == core_pkg::OPC_OP_IMM_32);
    assign word_form = (opcode == core_pkg::OPC_OP_32) ||
                       (opcode == core_pkg::OPC_OP_IMM_32);
    assign imm_sext  = {{(core_pkg::XLEN-12){in_item.instr.i.imm12[11]}},
                        in_item.instr.i.imm12};   // Low 6 bits double as shamt

    // Register is free when empty or being drained
    assign in_ready = !dec_valid || advance;

    // ----------------------------------------------------------
    // Opcode and funct3 to ALU controls
    // ----------------------------------------------------------
    always_comb begin
        dec_nxt        = '0;
        dec_nxt.opr_a  = in_item.rs1_val;
        dec_nxt.opr_b  = imm_form ? imm_sext : in_item.rs2_val;
        dec_nxt.funct3 = funct3;
        case (opcode)
            core_pkg::OPC_OP, core_pkg::OPC_OP_32,
            core_pkg::OPC_OP_IMM, core_pkg::OPC_OP_IMM_32: begin
                dec_nxt.ctl.word = word_form;
                case (funct3)
                    core_pkg::F3_ADD: begin
                        // Subtract only in register forms
                        dec_nxt.ctl.op_sub = !imm_form && alt;
                        dec_nxt.ctl.op_add = !(!imm_form && alt);
                    end
                    core_pkg::F3_SLL:  dec_nxt.ctl.op_sll  = 1'b1;
                    core_pkg::F3_SLT:  dec_nxt.ctl.op_slt  = 1'b1;
                    core_pkg::F3_SLTU: dec_nxt.ctl.op_sltu = 1'b1;
                    core_pkg::F3_XOR:  dec_nxt.ctl.op_xor  = 1'b1;
                    core_pkg::F3_SR: begin
                        dec_nxt.ctl.op_sra = alt;  // Bit 30 in all shift forms
                        dec_nxt.ctl.op_srl = !alt;
                    end
                    core_pkg::F3_OR:   dec_nxt.ctl.op_or   = 1'b1;
                    default:           dec_nxt.ctl.op_and  = 1'b1;
                endcase
                // Word opcodes only define add/sub and shifts
                if (word_form && !(funct3 == core_pkg::F3_ADD ||
                                   funct3 == core_pkg::F3_SLL ||
                                   funct3 == core_pkg::F3_SR)) begin
                    dec_nxt.ctl     = '0;
                    dec_nxt.illegal = 1'b1;
                end
            end
            core_pkg::OPC_BRANCH: begin
                dec_nxt.ctl.op_sub  = 1'b1;   // Drives compare flags, B is rs2
                dec_nxt.is_branch   = 1'b1;
            end
            default: dec_nxt.illegal = 1'b1;
        endcase
    end

    // ----------------------------------------------------------
    // Stage register
    // ----------------------------------------------------------
    always_ff @(posedge g_clk or negedge rst_n) begin
        if (!rst_n) begin
            dec_valid <= 1'b0;
        end else if (in_ready) begin
            dec_valid <= in_valid;
        end
    end

    always_ff @(posedge g_clk) begin
        if (in_valid && in_ready) begin
            dec <= dec_nxt;   // Load on accepted item only
        end
    end

endmodule

`default_nettype wire

//--- core_pipe_exec/core_pipe_exec.sv
/*
 * Integer execute stage, top level.
 * Decode register, ALU, branch evaluation and the output
 * register, linked by valid/ready with one item per cycle.
 */
`timescale 1ns/1ns
`default_nettype none

module core_pipe_exec (
    input  wire                  g_clk,
    input  wire                  rst_n,
    input  wire                  in_valid,
    output wire                  in_ready,
    input  core_pkg::exec_in_t   in_item,
    output logic                 out_valid,
    input  wire                  out_ready,
    output core_pkg::exec_res_t  out_item
);

    logic                  dec_valid;
    core_pkg::dec_t        dec;
    logic                  adv_out;      // Output register may load
    logic [core_pkg::XL:0] alu_result;
    logic                  cmp_eq;
    logic                  cmp_lt;
    logic                  cmp_ltu;
    logic                  taken;
    core_pkg::exec_res_t   res_nxt;

    // Empty or draining this cycle
    assign adv_out = !out_valid || out_ready;

    core_pipe_exec_decode u_decode (
        .g_clk     (g_clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_item   (in_item),
        .advance   (adv_out),
        .dec_valid (dec_valid),
        .dec       (dec)
    );

    core_pipe_exec_alu u_alu (
        .opr_a   (dec.opr_a),
        .opr_b   (dec.opr_b),
        .word    (dec.ctl.word),
        .op_add  (dec.ctl.op_add),
        .op_sub  (dec.ctl.op_sub),
        .op_xor  (dec.ctl.op_xor),
        .op_or   (dec.ctl.op_or),
        .op_and  (dec.ctl.op_and),
        .op_slt  (dec.ctl.op_slt),
        .op_sltu (dec.ctl.op_sltu),
        .op_srl  (dec.ctl.op_srl),
        .op_sll  (dec.ctl.op_sll),
        .op_sra  (dec.ctl.op_sra),
        .add_out (),               // Target adder lives elsewhere
        .cmp_eq  (cmp_eq),
        .cmp_lt  (cmp_lt),
        .cmp_ltu (cmp_ltu),
        .result  (alu_result)
    );

    core_pipe_exec_branch u_branch (
        .is_branch (dec.is_branch),
        .funct3    (dec.funct3),
        .cmp_eq    (cmp_eq),
        .cmp_lt    (cmp_lt),
        .cmp_ltu   (cmp_ltu),
        .taken     (taken)
    );

    // ----------------------------------------------------------
    // Output register
    // ----------------------------------------------------------
    assign res_nxt.result    = dec.illegal ? '0 : alu_result;
    assign res_nxt.taken     = taken;          // Low for illegal, is_branch clear
    assign res_nxt.is_branch = dec.is_branch;
    assign res_nxt.illegal   = dec.illegal;

    always_ff @(posedge g_clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (adv_out) begin
            out_valid <= dec_valid;
        end
    end

    always_ff @(posedge g_clk) begin
        if (adv_out && dec_valid) begin
            out_item <= res_nxt;
        end
    end

endmodule

`default_nettype wire

//--- tb/core_pipe_exec_vectors.svh
/*
 * Stimulus table for the execute stage testbench.
 * Included in the driver's initial block, one add_entry per item.
 */
// Columns: instruction, rs1_val, rs2_val, expected result,
//          expected flags {taken, is_branch, illegal}

// OP and OP-IMM, full width
add_entry(enc_r(7'h00, 3'd0, OP), 64'd5, 64'd7, 64'd12, F_ALU);
add_entry(enc_r(7'h00, 3'd0, OP), 64'h7fffffffffffffff, 64'd1, 64'h8000000000000000, F_ALU);
add_entry(enc_r(7'h20, 3'd0, OP), 64'd5, 64'd7, 64'hfffffffffffffffe, F_ALU);
add_entry(enc_r(7'h00, 3'd4, OP), 64'hff00ff00ff00ff00, 64'h0ff00ff00ff00ff0,
          64'hf0f0f0f0f0f0f0f0, F_ALU);
add_entry(enc_r(7'h00, 3'd6, OP), 64'hff00ff00ff00ff00, 64'h0ff00ff00ff00ff0,
          64'hfff0fff0fff0fff0, F_ALU);
add_entry(enc_r(7'h00, 3'd7, OP), 64'hff00ff00ff00ff00, 64'h0ff00ff00ff00ff0,
          64'h0f000f000f000f00, F_ALU);
add_entry(enc_r(7'h00, 3'd2, OP), 64'hffffffffffffffff, 64'd1, 64'd1, F_ALU);  // -1 < 1
add_entry(enc_r(7'h00, 3'd3, OP), 64'hffffffffffffffff, 64'd1, 64'd0, F_ALU);  // Max !< 1
add_entry(enc_i(12'hfff, 3'd0, OPI), 64'd10, 64'd100, 64'd9, F_ALU);
add_entry(enc_i(12'h800, 3'd2, OPI), 64'hfffffffffffff000, 64'd0, 64'd1, F_ALU);
add_entry(enc_i(12'hfff, 3'd3, OPI), 64'd5, 64'd0, 64'd1, F_ALU);
add_entry(enc_i(12'hfff, 3'd4, OPI), 64'h0123456789abcdef, 64'd0, 64'hfedcba9876543210, F_ALU);
add_entry(enc_i(12'h0f0, 3'd7, OPI), 64'h0123456789abcdef, 64'd0, 64'h00000000000000e0, F_ALU);
add_entry(enc_i(12'h800, 3'd6, OPI), 64'd1, 64'd0, 64'hfffffffffffff801, F_ALU);

// Word forms, upper operand bits are junk
add_entry(enc_r(7'h00, 3'd0, OPW), 64'hdeadbeef7fffffff, 64'd1, 64'hffffffff80000000, F_ALU);
add_entry(enc_r(7'h20, 3'd0, OPW), 64'h1234567800000000, 64'hffffffff00000001,
          64'hffffffffffffffff, F_ALU);
add_entry(enc_r(7'h00, 3'd1, OPW), 64'hffffffff00000001, 64'd31, 64'hffffffff80000000, F_ALU);
add_entry(enc_r(7'h00, 3'd5, OPW), 64'hffffffff80000000, 64'd63, 64'd1, F_ALU);  // Amount 31
add_entry(enc_r(7'h20, 3'd5, OPW), 64'h0000000080000000, 64'd4, 64'hfffffffff8000000, F_ALU);
add_entry(enc_i(12'h001, 3'd0, OPIW), 64'hffffffffffffffff, 64'd0, 64'd0, F_ALU);
add_entry(enc_i(12'h01f, 3'd1, OPIW), 64'd3, 64'd0, 64'hffffffff80000000, F_ALU);

// Full width shifts
add_entry(enc_r(7'h00, 3'd1, OP), 64'h8000000000000001, 64'd0, 64'h8000000000000001, F_ALU);
add_entry(enc_r(7'h00, 3'd1, OP), 64'h8000000000000001, 64'd63, 64'h8000000000000000, F_ALU);
add_entry(enc_r(7'h00, 3'd5, OP), 64'h8000000000000000, 64'd1, 64'h4000000000000000, F_ALU);
add_entry(enc_r(7'h00, 3'd5, OP), 64'hf000000000000000, 64'd32, 64'h00000000f0000000, F_ALU);
add_entry(enc_r(7'h20, 3'd5, OP), 64'h8000000000000000, 64'd31, 64'hffffffff00000000, F_ALU);
add_entry(enc_r(7'h20, 3'd5, OP), 64'h8000000000000000, 64'd63, 64'hffffffffffffffff, F_ALU);
add_entry(enc_i(12'h420, 3'd5, OPI), 64'h8000000000000000, 64'd0, 64'hffffffff80000000, F_ALU);
add_entry(enc_i(12'h401, 3'd5, OPI), 64'h4000000000000000, 64'd0, 64'h2000000000000000, F_ALU);

// Branches, result is rs1 - rs2
add_entry(enc_r(7'h00, 3'd0, BR), 64'd5, 64'd5, 64'd0, F_BT);
add_entry(enc_r(7'h00, 3'd1, BR), 64'd5, 64'd5, 64'd0, F_BN);
add_entry(enc_r(7'h00, 3'd4, BR), 64'hffffffffffffffff, 64'd1, 64'hfffffffffffffffe, F_BT);
add_entry(enc_r(7'h00, 3'd5, BR), 64'hffffffffffffffff, 64'd1, 64'hfffffffffffffffe, F_BN);
add_entry(enc_r(7'h00, 3'd6, BR), 64'hffffffffffffffff, 64'd1, 64'hfffffffffffffffe, F_BN);
add_entry(enc_r(7'h00, 3'd7, BR), 64'hffffffffffffffff, 64'd1, 64'hfffffffffffffffe, F_BT);

// Unsupported encodings
add_entry(enc_i(12'h010, 3'd3, LOAD), 64'd5, 64'd6, 64'd0, F_ILL);
add_entry(enc_r(7'h00, 3'd4, OPW), 64'd5, 64'd6, 64'd0, F_ILL);   // No XORW

//--- tb/core_pipe_exec_tb.sv
/*
 * Testbench for the integer execute stage.
 * Streams a table of instructions through the DUT under random
 * output back-pressure and checks every result in order.
 */
`timescale 1ns/1ns
`default_nettype none

module core_pipe_exec_tb;

    // RV64 major opcodes from the ISA encoding tables
    localparam logic [6:0] OP    = 7'b0110011;
    localparam logic [6:0] OPI   = 7'b0010011;
    localparam logic [6:0] OPW   = 7'b0111011;
    localparam logic [6:0] OPIW  = 7'b0011011;
    localparam logic [6:0] BR    = 7'b1100011;
    localparam logic [6:0] LOAD  = 7'b0000011;

    // Expected flags as {taken, is_branch, illegal}
    localparam logic [2:0] F_ALU = 3'b000;
    localparam logic [2:0] F_BT  = 3'b110;   // Branch taken
    localparam logic [2:0] F_BN  = 3'b010;   // Branch not taken
    localparam logic [2:0] F_ILL = 3'b001;

    localparam int TIMEOUT = 200;             // Cycles per wait

    logic                g_clk = 1'b0;
    logic                rst_n = 1'b0;
    logic                in_valid = 1'b0;
    logic                in_ready;
    core_pkg::exec_in_t  in_item = '0;
    logic                out_valid;
    logic                out_ready;
    core_pkg::exec_res_t out_item;

    // Stimulus table
    logic [31:0]         tab_instr[$];
    logic [63:0]         tab_rs1[$];
    logic [63:0]         tab_rs2[$];
    core_pkg::exec_res_t tab_exp[$];

    int     errors = 0;
    int     n_out  = 0;                       // Items seen at the output
    integer seed   = 32'h9308_84bb;

    core_pipe_exec UUT (
        .g_clk     (g_clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_item   (in_item),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_item  (out_item)
    );

    always #5 g_clk = ~g_clk;                 // 10 ns period

    // ----------------------------------------------------------
    // Encoders and table helpers
    // ----------------------------------------------------------
    // R-type with rs1=x1, rs2=x2, rd=x3
    function automatic logic [31:0] enc_r(input logic [6:0] funct7, input logic [2:0] funct3,
                                          input logic [6:0] opcode);
        return {funct7, 5'd2, 5'd1, funct3, 5'd3, opcode};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm12, input logic [2:0] funct3,
                                          input logic [6:0] opcode);
        return {imm12, 5'd1, funct3, 5'd3, opcode};
    endfunction

    task automatic add_entry(input logic [31:0] instr, input logic [63:0] rs1,
                             input logic [63:0] rs2, input logic [63:0] result,
                             input logic [2:0] flags);
        core_pkg::exec_res_t exp;
        exp.result    = result;
        exp.taken     = flags[2];
        exp.is_branch = flags[1];
        exp.illegal   = flags[0];
        tab_instr.push_back(instr);
        tab_rs1.push_back(rs1);
        tab_rs2.push_back(rs2);
        tab_exp.push_back(exp);
    endtask

    // ----------------------------------------------------------
    // Output checker
    // ----------------------------------------------------------
    task automatic check_field(input string name, input int idx, input logic [63:0] exp,
                               input logic [63:0] got);
        assert (got === exp) else begin
            errors++;
            $display("ERR %0t ns item %0d %s expected %h got %h", $time, idx, name, exp, got);
        end
    endtask

    task automatic check_output(input core_pkg::exec_res_t got);
        core_pkg::exec_res_t exp;
        assert (n_out < tab_exp.size()) else begin
            errors++;
            $display("Extra output item %0d beyond the end of the table at %0t ns",
                     n_out, $time);
        end
        if (n_out < tab_exp.size()) begin
            exp = tab_exp[n_out];
            check_field("result", n_out, exp.result, got.result);
            check_field("taken", n_out, 64'(exp.taken), 64'(got.taken));
            check_field("is_branch", n_out, 64'(exp.is_branch), 64'(got.is_branch));
            check_field("illegal", n_out, 64'(exp.illegal), 64'(got.illegal));
        end
        n_out++;
    endtask

    // Sample on the handshake edge itself
    always @(posedge g_clk) begin
        if (rst_n && out_valid && out_ready) begin
            check_output(out_item);
        end
    end

    // Random back-pressure with out_ready low about a third of the time
    initial begin
        out_ready = 1'b0;
        forever begin
            @(posedge g_clk);
            #1 out_ready = ($random(seed) % 3) != 0;
        end
    end

    task automatic end_run(input bit timed_out);
        $display("Done: %0d errors, %0d of %0d items received", errors, n_out, tab_exp.size());
        if (errors == 0 && n_out == tab_exp.size() && !timed_out) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    endtask

    // ----------------------------------------------------------
    // Driver
    // ----------------------------------------------------------
    initial begin
        int i;
        int wait_cnt;
        bit accepted;
        bit timed_out;
        `include "core_pipe_exec_vectors.svh"

        timed_out = 1'b0;
        repeat (4) @(posedge g_clk);
        #1 rst_n = 1'b1;

        for (i = 0; i < tab_instr.size() && !timed_out; i++) begin
            in_valid = 1'b1;
            in_item  = {tab_instr[i], tab_rs1[i], tab_rs2[i]};
            wait_cnt = 0;
            do begin
                @(negedge g_clk);
                accepted = in_ready;          // Settled mid-cycle
                @(posedge g_clk);
                #1;
                wait_cnt++;
            end while (!accepted && wait_cnt < TIMEOUT);
            if (!accepted) begin
                $display("Timeout waiting for in_ready on item %0d", i);
                timed_out = 1'b1;
            end
        end
        in_valid = 1'b0;

        if (!timed_out) begin
            wait_cnt = 0;
            while (n_out < tab_exp.size() && wait_cnt < TIMEOUT) begin
                @(negedge g_clk);
                wait_cnt++;
            end
            if (n_out < tab_exp.size()) begin
                $display("Timeout waiting for the pipeline to drain");
                timed_out = 1'b1;
            end else begin
                repeat (5) @(posedge g_clk);      // Window for stray duplicates
                assert (n_out == tab_exp.size()) else begin
                    errors++;
                    $display("Received %0d items but the table holds %0d",
                             n_out, tab_exp.size());
                end
            end
        end
        end_run(timed_out);
    end

endmodule

`default_nettype wire

//--- core_exec.f
+incdir+tb
common/core_pkg.sv
core_pipe_exec/core_pipe_exec_alu.sv
core_pipe_exec/core_pipe_exec_branch.sv
core_pipe_exec/core_pipe_exec_decode.sv
core_pipe_exec/core_pipe_exec.sv
tb/core_pipe_exec_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the execute stage testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
    --top-module core_pipe_exec_tb \
    -f core_exec.f

./obj_dir/Vcore_pipe_exec_tb | tee sim.log

if grep -q "test failed" sim.log; then
    echo "Simulation reported a failure, see sim.log"
    exit 1
fi
if ! grep -q "test passed" sim.log; then
    echo "Simulation ended without a result line, see sim.log"
    exit 1
fi
echo "Simulation clean"
